// ==== periph_subsys.f ====
logic/periph_pkg.sv
logic/bus_bridge.sv
logic/far_fabric.sv
logic/machine_timer.sv
logic/irq_ctrl.sv
logic/periph_subsys.sv
sim/tb_clock.sv
sim/periph_subsys_chk.sv
sim/periph_subsys_tb.sv

// ==== sim/periph_subsys_tb.sv ====
module periph_subsys_tb import periph_pkg::*; ();

	localparam int LED_W      = 10;
	localparam int TICK_DIV   = 4;
	localparam int NUM_SRC    = 4;
	localparam int PERIOD     = 8;
	localparam int RST_CYCLES = 10;
	localparam int LATENCY    = 3;

	// Ticks that may pass between a time write and the next read
	localparam int MAX_TICKS = (LATENCY + 1) / TICK_DIV + 1;

	localparam int IRQ_GAP         = 16;
	localparam int IRQ_RISE_CYCLES = TICK_DIV * IRQ_GAP + 2;

	// Transactions per test: latency, LED, timer count, timer irq, irq ctrl
	localparam int NUM_TRANS       = 29 + 16 + 32 + 7 + 32;
	localparam int IRQ_WAIT_CYCLES = 20 + IRQ_RISE_CYCLES + 4 * 8;
	localparam int WATCHDOG_CYCLES = NUM_TRANS * 10 + IRQ_WAIT_CYCLES + RST_CYCLES;

	logic               clock;
	logic               arst_n;
	logic               request;
	near_req_t          near;
	rsp_t               rsp;
	logic [NUM_SRC-1:0] irq_src;
	logic [LED_W-1:0]   led;
	logic               timer_irq;
	logic               ext_irq;

	// Register model
	data_t              cmp_lo_m  = '1;
	data_t              cmp_hi_m  = '1;
	data_t              time_lo_m = '0;
	data_t              time_hi_m = '0;
	logic [NUM_SRC-1:0] en_m      = '0;
	logic [NUM_SRC-1:0] pend_m    = '0;
	logic [LED_W-1:0]   led_m     = '0;

	// Pending comparisons
	data_t act_q[$];
	data_t exp_q[$];
	string msg_q[$];

	int checks_n    = 0;
	int errors_n    = 0;
	int checks_mark = 0;
	int errors_mark = 0;

	tb_clock #(.PERIOD(PERIOD)) clk0 (.o_clock(clock));

	periph_subsys #(
		.LED_W    (LED_W),
		.TICK_DIV (TICK_DIV),
		.NUM_SRC  (NUM_SRC)
	) dut0 (
		.i_clock     (clock),
		.i_arst_n    (arst_n),
		.i_request   (request),
		.i_near      (near),
		.o_rsp       (rsp),
		.i_irq_src   (irq_src),
		.o_led       (led),
		.o_timer_irq (timer_irq),
		.o_ext_irq   (ext_irq)
	);

	bind periph_subsys periph_subsys_chk #(.NUM_SRC(NUM_SRC)) chk0 (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_request     (i_request),
		.i_rsp_ready   (o_rsp.ready),
		.i_far_request (far_request),
		.i_far_addr    (far_addr),
		.i_far_req     (far_req),
		.i_ext_irq     (o_ext_irq)
	);

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic data_t ref_read(input region_t region, input word_t word);
		logic [NUM_SRC-1:0] act;
		data_t              val;
		bit                 found;
		int                 i;
		act   = pend_m & en_m;
		val   = '0;
		found = 1'b0;
		i     = 0;
		if (region == REGION_TIMER) begin
			case (word)
				3'd0:    val = time_lo_m;
				3'd1:    val = time_hi_m;
				3'd2:    val = cmp_lo_m;
				3'd3:    val = cmp_hi_m;
				default: val = '0;
			endcase
		end else if (region == REGION_IRQ) begin
			case (word)
				3'd0: val = data_t'(en_m);
				3'd1: val = data_t'(pend_m);
				3'd2: begin
					// Scan upward, first hit is the claim
					while (!found && i < NUM_SRC) begin
						if (act[i]) begin
							val   = data_t'(i + 1);
							found = 1'b1;
						end
						i++;
					end
				end
				default: val = '0;
			endcase
		end
		return val;
	endfunction

	function automatic void model_write(input region_t region, input word_t word,
		input data_t wdata);
		if (region == REGION_LED)
			led_m = wdata[LED_W-1:0];
		if (region == REGION_TIMER) begin
			case (word)
				3'd0:    time_lo_m = wdata;
				3'd1:    time_hi_m = wdata;
				3'd2:    cmp_lo_m  = wdata;
				3'd3:    cmp_hi_m  = wdata;
				default: ;
			endcase
		end
		if (region == REGION_IRQ && word == 3'd0)
			en_m = wdata[NUM_SRC-1:0];
	endfunction

	// ========================================================================
	// Checking
	// ========================================================================

	task automatic compare_values(input data_t act, input data_t exp, input string msg);
		checks_n++;
		if (act !== exp) begin
			errors_n++;
			$display("** Error at time %0t: %s (got %h, expected %h)", $time, msg, act, exp);
		end
	endtask

	function automatic void expect_value(input data_t act, input data_t exp,
		input string msg);
		act_q.push_back(act);
		exp_q.push_back(exp);
		msg_q.push_back(msg);
	endfunction

	// Compare process, drains what the stimulus queued at the falling edge
	always @(posedge clock) begin : compare_proc
		data_t act;
		data_t exp;
		string msg;
		while (act_q.size() > 0) begin
			act = act_q.pop_front();
			exp = exp_q.pop_front();
			msg = msg_q.pop_front();
			compare_values(act, exp, msg);
		end
	end

	task automatic finish_test(input string name);
		while (act_q.size() != 0)
			@(negedge clock);
		@(negedge clock);
		$display("%-16s %0d checks, %0d errors", name, checks_n - checks_mark,
			errors_n - errors_mark);
		checks_mark = checks_n;
		errors_mark = errors_n;
	endtask

	// ========================================================================
	// Bus tasks
	// ========================================================================

	function automatic addr_t make_addr(input region_t region, input word_t word);
		logic [18:0] fill;
		fill = 19'($urandom);
		return {region, fill, word, 2'b00};
	endfunction

	// Called at a falling edge, returns one idle cycle after ready
	task automatic drive_transfer(input logic rw, input addr_t addr, input data_t wdata,
		output data_t rdata, output int cycles);
		request = 1'b1;
		near    = '{rw: rw, address: addr, wdata: wdata};
		cycles  = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!rsp.ready);
		rdata   = rsp.rdata;
		request = 1'b0;
		@(negedge clock);
	endtask

	task automatic bus_write(input region_t region, input word_t word, input data_t wdata);
		data_t rd;
		int    lat;
		drive_transfer(1'b1, make_addr(region, word), wdata, rd, lat);
		model_write(region, word, wdata);
		expect_value(data_t'(lat), LATENCY, $sformatf("write r%0h latency", region));
		expect_value(rd, '0, $sformatf("write r%0h w%0d rdata", region, word));
	endtask

	task automatic bus_read(input region_t region, input word_t word, input bit exact,
		output data_t rdata);
		data_t exp;
		int    lat;
		exp = ref_read(region, word);
		drive_transfer(1'b0, make_addr(region, word), '0, rdata, lat);
		expect_value(data_t'(lat), LATENCY, $sformatf("read r%0h latency", region));
		if (exact)
			expect_value(rdata, exp, $sformatf("read r%0h w%0d", region, word));
		// Claim side effect
		if (region == REGION_IRQ && word == 3'd2 && exp != '0)
			pend_m[exp - 1] = 1'b0;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic sweep_latency();
		data_t rd;
		expect_value(data_t'(timer_irq), 0, "timer irq after reset");
		expect_value(data_t'(ext_irq), 0, "ext irq after reset");
		expect_value(data_t'(led), 0, "led after reset");
		for (int r = 0; r < 16; r++) begin
			bus_read(region_t'(r), 3'd2, 1'b1, rd);
			if (r != REGION_LED && r != REGION_TIMER && r != REGION_IRQ)
				bus_write(region_t'(r), word_t'($urandom), $urandom);
		end
		finish_test("latency");
	endtask

	task automatic exercise_led();
		data_t rd;
		word_t w;
		for (int i = 0; i < 8; i++) begin
			w = word_t'($urandom);
			bus_write(REGION_LED, w, $urandom);
			expect_value(data_t'(led), data_t'(led_m), "led after write");
			bus_read(REGION_LED, word_t'($urandom), 1'b1, rd);
			expect_value(data_t'(led), data_t'(led_m), "led after read");
		end
		finish_test("led");
	endtask

	task automatic verify_timer_count();
		data_t rd;
		data_t v;
		for (int i = 0; i < 4; i++) begin
			v = $urandom & 32'h7fff_ffff;
			// High compare half keeps the interrupt far away
			bus_write(REGION_TIMER, 3'd2, $urandom);
			bus_write(REGION_TIMER, 3'd3, $urandom | 32'h8000_0000);
			bus_write(REGION_TIMER, 3'd1, '0);
			bus_write(REGION_TIMER, 3'd0, v);
			bus_read(REGION_TIMER, 3'd0, 1'b0, rd);
			expect_value(data_t'(rd >= v && rd <= v + MAX_TICKS), 1,
				$sformatf("time low %h outside window from %h", rd, v));
			bus_read(REGION_TIMER, 3'd1, 1'b1, rd);
			bus_read(REGION_TIMER, 3'd2, 1'b1, rd);
			bus_read(REGION_TIMER, 3'd3, 1'b1, rd);
			expect_value(data_t'(timer_irq), 0, "timer irq with compare ahead");
		end
		finish_test("timer count");
	endtask

	task automatic raise_timer_irq();
		data_t t;
		int    n;
		bus_write(REGION_TIMER, 3'd3, '1);
		bus_write(REGION_TIMER, 3'd2, $urandom);
		repeat (20) @(negedge clock);
		expect_value(data_t'(timer_irq), 0, "timer irq with compare far ahead");
		bus_write(REGION_TIMER, 3'd1, '0);
		bus_write(REGION_TIMER, 3'd0, '0);
		bus_read(REGION_TIMER, 3'd0, 1'b0, t);
		// Low half first so compare never drops below time
		bus_write(REGION_TIMER, 3'd2, t + IRQ_GAP);
		bus_write(REGION_TIMER, 3'd3, '0);
		expect_value(data_t'(timer_irq), 0, "timer irq before compare reached");
		n = 0;
		while (!timer_irq && n < IRQ_RISE_CYCLES) begin
			@(negedge clock);
			n++;
		end
		expect_value(data_t'(timer_irq), 1,
			$sformatf("timer irq not raised within %0d cycles", IRQ_RISE_CYCLES));
		finish_test("timer irq");
	endtask

	task automatic claim_interrupts();
		data_t              rd;
		logic [NUM_SRC-1:0] src;
		int                 n;
		for (int round = 0; round < 4; round++) begin
			src = NUM_SRC'($urandom);
			bus_write(REGION_IRQ, 3'd0, data_t'(NUM_SRC'($urandom)));
			irq_src = src;
			repeat (3) @(negedge clock);
			irq_src = '0;
			// Synchronizer and edge latch settle
			repeat (4) @(negedge clock);
			pend_m = pend_m | src;
			bus_read(REGION_IRQ, 3'd0, 1'b1, rd);
			bus_read(REGION_IRQ, 3'd1, 1'b1, rd);
			expect_value(data_t'(ext_irq), data_t'(|(pend_m & en_m)), "ext irq level");
			n = $countones(pend_m & en_m);
			for (int k = 0; k <= n; k++)
				bus_read(REGION_IRQ, 3'd2, 1'b1, rd);
			expect_value(data_t'(ext_irq), 0, "ext irq after claims");
		end
		finish_test("irq ctrl");
	endtask

	// ========================================================================
	// Main sequence and watchdog
	// ========================================================================

	initial begin
		void'($urandom(32'h036a_3d24));
		arst_n  = 1'b0;
		request = 1'b0;
		near    = '0;
		irq_src = '0;
		repeat (RST_CYCLES) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		sweep_latency();
		exercise_led();
		verify_timer_count();
		raise_timer_irq();
		claim_interrupts();

		$display("Checks %0d, errors %0d, assertion failures %0d", checks_n, errors_n,
			dut0.chk0.fails);
		if (errors_n == 0 && dut0.chk0.fails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the run did not complete",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== sim/periph_subsys_chk.sv ====
module periph_subsys_chk import periph_pkg::*; #(
	parameter int NUM_SRC = 4
) (
	input logic     i_clock,
	input logic     i_arst_n,
	input logic     i_request,
	input logic     i_rsp_ready,
	input logic     i_far_request,
	input region_t  i_far_addr,
	input far_req_t i_far_req,
	input logic     i_ext_irq
);

	int unsigned        fails = 0;
	logic               busy;
	logic               outstanding;
	logic [NUM_SRC-1:0] enable_shadow;

	// Far transaction in flight, from far pulse to near ready
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			busy <= 1'b0;
		else if (i_far_request)
			busy <= 1'b1;
		else if (i_rsp_ready)
			busy <= 1'b0;
	end

	// Near transaction outstanding, from first request sample to ready
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			outstanding <= 1'b0;
		else if (i_rsp_ready)
			outstanding <= 1'b0;
		else if (i_request)
			outstanding <= 1'b1;
	end

	// Enable mask as written over the far bus
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			enable_shadow <= '0;
		else if (i_far_request && i_far_addr == REGION_IRQ && i_far_req.rw
			&& i_far_req.word == 3'd0)
			enable_shadow <= i_far_req.wdata[NUM_SRC-1:0];
	end

	ready_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_rsp_ready |=> !i_rsp_ready)
		else begin
			$error("near ready held for more than one cycle");
			fails++;
		end

	ready_has_request: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_rsp_ready |-> outstanding)
		else begin
			$error("near ready without a request outstanding");
			fails++;
		end

	far_one_at_a_time: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_far_request |-> !busy)
		else begin
			$error("far request raised during an outstanding transaction");
			fails++;
		end

	ext_irq_enabled: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_ext_irq |-> (enable_shadow != '0))
		else begin
			$error("external interrupt with an empty enable mask");
			fails++;
		end

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic o_clock
);

	// Free-running, starts low
	initial begin
		o_clock = 1'b0;
		forever #(PERIOD / 2) o_clock = ~o_clock;
	end

endmodule

// ==== logic/periph_subsys.sv ====
module periph_subsys import periph_pkg::*; #(
	parameter int LED_W    = 10,
	parameter int TICK_DIV = 100,
	parameter int NUM_SRC  = 4
) (
	input  logic               i_clock,
	input  logic               i_arst_n,

	// Near bus
	input  logic               i_request,
	input  near_req_t          i_near,
	output rsp_t               o_rsp,

	input  logic [NUM_SRC-1:0] i_irq_src,
	output logic [LED_W-1:0]   o_led,
	output logic               o_timer_irq,
	output logic               o_ext_irq
);

	// Far bus
	logic     far_request;
	region_t  far_addr;
	far_req_t far_req;
	rsp_t     far_rsp;

	// Per-peripheral handshake
	logic     timer_request;
	logic     irq_request;
	rsp_t     timer_rsp;
	rsp_t     irq_rsp;

	// ========================================================================
	// Bridge and far fabric
	// ========================================================================

	bus_bridge bridge (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_request     (i_request),
		.i_near        (i_near),
		.o_rsp         (o_rsp),
		.o_far_request (far_request),
		.o_far_addr    (far_addr),
		.o_far_req     (far_req),
		.i_far_rsp     (far_rsp)
	);

	far_fabric #(
		.LED_W (LED_W)
	) fabric (
		.i_clock         (i_clock),
		.i_arst_n        (i_arst_n),
		.i_far_request   (far_request),
		.i_far_addr      (far_addr),
		.i_far_req       (far_req),
		.o_far_rsp       (far_rsp),
		.o_timer_request (timer_request),
		.o_irq_request   (irq_request),
		.i_timer_rsp     (timer_rsp),
		.i_irq_rsp       (irq_rsp),
		.o_led           (o_led)
	);

	// ========================================================================
	// Peripherals
	// ========================================================================

	machine_timer #(
		.TICK_DIV (TICK_DIV)
	) timer (
		.i_clock     (i_clock),
		.i_arst_n    (i_arst_n),
		.i_request   (timer_request),
		.i_req       (far_req),
		.o_rsp       (timer_rsp),
		.o_timer_irq (o_timer_irq)
	);

	irq_ctrl #(
		.NUM_SRC (NUM_SRC)
	) irq (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_request (irq_request),
		.i_req     (far_req),
		.o_rsp     (irq_rsp),
		.i_irq_src (i_irq_src),
		.o_ext_irq (o_ext_irq)
	);

endmodule

// ==== logic/irq_ctrl.sv ====
module irq_ctrl import periph_pkg::*; #(
	parameter int NUM_SRC = 4
) (
	input  logic               i_clock,
	input  logic               i_arst_n,

	// Far bus
	input  logic               i_request,
	input  far_req_t           i_req,
	output rsp_t               o_rsp,

	// Interrupt sources and the combined line
	input  logic [NUM_SRC-1:0] i_irq_src,
	output logic               o_ext_irq
);

	logic [NUM_SRC-1:0] src_meta;
	logic [NUM_SRC-1:0] src_sync;
	logic [NUM_SRC-1:0] src_prev;
	logic [NUM_SRC-1:0] rise;
	logic [NUM_SRC-1:0] enable_q;
	logic [NUM_SRC-1:0] pending_q;
	logic [NUM_SRC-1:0] active;
	logic [NUM_SRC-1:0] claim_mask;
	data_t              claim_val;
	logic               wr;
	logic               rd;
	logic               claim_rd;
	logic               rsp_ready;
	data_t              rsp_rdata;
	data_t              rd_mux;

	assign wr       = i_request && i_req.rw;
	assign rd       = i_request && !i_req.rw;
	assign claim_rd = rd && (i_req.word == 3'd2);

	// ========================================================================
	// Source synchronizer and edge detect
	// ========================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			src_meta <= '0;
			src_sync <= '0;
			src_prev <= '0;
		end else begin
			src_meta <= i_irq_src;
			src_sync <= src_meta;
			src_prev <= src_sync;
		end
	end

	assign rise   = src_sync & ~src_prev;
	assign active = pending_q & enable_q;

	// Lowest active source wins the claim
	always_comb begin
		claim_val  = '0;
		claim_mask = '0;
		for (int i = NUM_SRC - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_val  = data_t'(i + 1);
				claim_mask = NUM_SRC'(1) << i;
			end
		end
	end

	// ========================================================================
	// Enable and pending registers
	// ========================================================================

	// A new edge in the claim cycle is kept
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			enable_q  <= '0;
			pending_q <= '0;
		end else begin
			if (wr && i_req.word == 3'd0)
				enable_q <= i_req.wdata[NUM_SRC-1:0];
			pending_q <= (pending_q & ~(claim_rd ? claim_mask : '0)) | rise;
		end
	end

	assign o_ext_irq = |active;

	// ========================================================================
	// Read mux and response
	// ========================================================================

	always_comb begin
		case (i_req.word)
			3'd0:    rd_mux = data_t'(enable_q);
			3'd1:    rd_mux = data_t'(pending_q);
			3'd2:    rd_mux = claim_val;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			rsp_ready <= 1'b0;
		else
			rsp_ready <= i_request;
	end

	always_ff @(posedge i_clock) begin
		rsp_rdata <= rd ? rd_mux : '0;
	end

	assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// ==== logic/machine_timer.sv ====
module machine_timer import periph_pkg::*; #(
	parameter int TICK_DIV = 100
) (
	input  logic     i_clock,
	input  logic     i_arst_n,

	// Far bus
	input  logic     i_request,
	input  far_req_t i_req,
	output rsp_t     o_rsp,

	output logic     o_timer_irq
);

	typedef logic [63:0] mtime_t;

	localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [PW-1:0] presc;
	logic          tick;
	mtime_t        mtime;
	mtime_t        mtimecmp;
	logic          wr;
	logic          rd;
	logic          rsp_ready;
	data_t         rsp_rdata;
	data_t         rd_mux;

	assign wr = i_request && i_req.rw;
	assign rd = i_request && !i_req.rw;

	// ========================================================================
	// Prescaler and time counter
	// ========================================================================

	assign tick = (presc == PW'(TICK_DIV - 1));

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			presc <= '0;
		end else if (tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	// Bus writes take priority over the tick
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (wr && i_req.word == 3'd0)
				mtime <= {mtime[63:32], i_req.wdata};
			else if (wr && i_req.word == 3'd1)
				mtime <= {i_req.wdata, mtime[31:0]};
			else if (tick)
				mtime <= mtime + 64'd1;

			if (wr && i_req.word == 3'd2)
				mtimecmp[31:0] <= i_req.wdata;
			if (wr && i_req.word == 3'd3)
				mtimecmp[63:32] <= i_req.wdata;
		end
	end

	// ========================================================================
	// Read mux and response
	// ========================================================================

	always_comb begin
		case (i_req.word)
			3'd0:    rd_mux = mtime[31:0];
			3'd1:    rd_mux = mtime[63:32];
			3'd2:    rd_mux = mtimecmp[31:0];
			3'd3:    rd_mux = mtimecmp[63:32];
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rsp_ready   <= 1'b0;
			o_timer_irq <= 1'b0;
		end else begin
			rsp_ready   <= i_request;
			o_timer_irq <= (mtime >= mtimecmp);
		end
	end

	// Zero on writes
	always_ff @(posedge i_clock) begin
		rsp_rdata <= rd ? rd_mux : '0;
	end

	assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// ==== logic/far_fabric.sv ====
module far_fabric import periph_pkg::*; #(
	parameter int LED_W = 10
) (
	input  logic             i_clock,
	input  logic             i_arst_n,

	// From the bridge
	input  logic             i_far_request,
	input  region_t          i_far_addr,
	input  far_req_t         i_far_req,
	output rsp_t             o_far_rsp,

	// Peripheral requests and responses
	output logic             o_timer_request,
	output logic             o_irq_request,
	input  rsp_t             i_timer_rsp,
	input  rsp_t             i_irq_rsp,

	// Board LEDs
	output logic [LED_W-1:0] o_led
);

	logic             led_sel;
	logic             timer_sel;
	logic             irq_sel;
	logic             local_sel;
	logic             local_ready;
	logic [LED_W-1:0] led_q;

	// ========================================================================
	// Region decode
	// ========================================================================

	always_comb begin
		led_sel   = 1'b0;
		timer_sel = 1'b0;
		irq_sel   = 1'b0;
		case (i_far_addr)
			REGION_LED:   led_sel   = 1'b1;
			REGION_TIMER: timer_sel = 1'b1;
			REGION_IRQ:   irq_sel   = 1'b1;
			default:      ;
		endcase
	end

	// LED and unmapped regions are answered here
	assign local_sel = !(timer_sel || irq_sel);

	assign o_timer_request = i_far_request && timer_sel;
	assign o_irq_request   = i_far_request && irq_sel;

	// ========================================================================
	// LED register and local ready
	// ========================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			local_ready <= 1'b0;
			led_q       <= '0;
		end else begin
			local_ready <= i_far_request && local_sel;
			// Write-only, reads fall through to zero
			if (i_far_request && led_sel && i_far_req.rw)
				led_q <= i_far_req.wdata[LED_W-1:0];
		end
	end

	assign o_led = led_q;

	// Response mux, address is held by the bridge until ready
	always_comb begin
		if (timer_sel)
			o_far_rsp = i_timer_rsp;
		else if (irq_sel)
			o_far_rsp = i_irq_rsp;
		else
			o_far_rsp = '{ready: local_ready, rdata: '0};
	end

endmodule

// ==== logic/bus_bridge.sv ====
module bus_bridge import periph_pkg::*; (
	input  logic      i_clock,
	input  logic      i_arst_n,

	// Near side
	input  logic      i_request,
	input  near_req_t i_near,
	output rsp_t      o_rsp,

	// Far side
	output logic      o_far_request,
	output region_t   o_far_addr,
	output far_req_t  o_far_req,
	input  rsp_t      i_far_rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RESPOND
	} state_t;

	state_t    state;
	logic      far_request;
	logic      rsp_ready;
	near_req_t near_q;
	data_t     rsp_rdata;
	logic      accept;
	logic      far_done;

	// Start only from idle, the master holds request until ready
	assign accept   = (state == ST_IDLE) && i_request;
	assign far_done = (state == ST_WAIT) && i_far_rsp.ready;

	// ========================================================================
	// Transaction FSM
	// ========================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state       <= ST_IDLE;
			far_request <= 1'b0;
			rsp_ready   <= 1'b0;
		end else begin
			far_request <= 1'b0;
			rsp_ready   <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_request) begin
						far_request <= 1'b1;
						state       <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (i_far_rsp.ready) begin
						rsp_ready <= 1'b1;
						state     <= ST_RESPOND;
					end
				end
				// One cycle for the master to drop its request
				ST_RESPOND: state <= ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	// Captured request and returned data
	always_ff @(posedge i_clock) begin
		if (accept)
			near_q <= i_near;
		if (far_done)
			rsp_rdata <= i_far_rsp.rdata;
	end

	// ========================================================================
	// Outputs
	// ========================================================================

	assign o_far_request = far_request;
	assign o_far_addr    = near_q.address[REGION_LSB +: $bits(region_t)];

	assign o_far_req = '{
		rw:    near_q.rw,
		word:  near_q.address[WORD_LSB +: $bits(word_t)],
		wdata: near_q.wdata
	};

	assign o_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

endmodule

// ==== logic/periph_pkg.sv ====
package periph_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Near-bus byte address
	typedef logic [27:0] addr_t;

	// Bus data word
	typedef logic [31:0] data_t;

	// Far region code, address bits 27..24
	typedef logic [3:0] region_t;

	// Register word index inside a region, address bits 4..2
	typedef logic [2:0] word_t;

	// Where the region and word fields sit in the near address
	localparam int REGION_LSB = 24;
	localparam int WORD_LSB   = 2;

	// ========================================================================
	// Far region map
	// ========================================================================

	localparam region_t REGION_LED   = 4'h0;
	localparam region_t REGION_TIMER = 4'h5;
	localparam region_t REGION_IRQ   = 4'h8;

	// ========================================================================
	// Bus payloads
	// ========================================================================

	// rw is high for a write and low for a read
	typedef struct packed {
		logic  rw;
		addr_t address;
		data_t wdata;
	} near_req_t;

	// Region already decoded by the fabric, only the word index remains
	typedef struct packed {
		logic  rw;
		word_t word;
		data_t wdata;
	} far_req_t;

	// Ready is a single-cycle pulse with rdata valid alongside
	typedef struct packed {
		logic  ready;
		data_t rdata;
	} rsp_t;

endpackage
